// File: common/mem_tile_pkg.sv
/*
 * Memory tile shared definitions
 * Widths, request opcodes and the request/response structs used
 * between the atomic resolver, the register cut and the SRAM banks
 */

package mem_tile_pkg;

  // Byte address and word widths
  localparam int unsigned AddrWidth       = 16;
  localparam int unsigned DataWidth       = 64;

  // One bank lane per 32 bits of the word
  localparam int unsigned BankDataWidth   = 32;
  localparam int unsigned NumBanksPerWord = DataWidth / BankDataWidth;

  // Atomics work on one 32-bit lane, picked by address bit 2
  localparam int unsigned AmoWidth        = 32;

  typedef enum logic [2:0] {
    MEM_READ,
    MEM_WRITE,
    AMO_SWAP,
    AMO_ADD,
    AMO_AND,
    AMO_OR,
    AMO_MAXU,
    AMO_MINU
  } mem_op_e;

  typedef struct packed {
    mem_op_e                  op;
    logic [AddrWidth-1:0]     addr;
    logic [DataWidth-1:0]     wdata;
    logic [DataWidth/8-1:0]   be;
  } mem_req_t;

  typedef struct packed {
    logic                     we;
    logic [AddrWidth-1:0]     addr;
    logic [DataWidth-1:0]     wdata;
    logic [DataWidth/8-1:0]   be;
  } sram_req_t;

  typedef struct packed {
    logic [DataWidth-1:0]     rdata;
  } mem_rsp_t;

endpackage

// File: sram/sram_macro.sv
/*
 * Single-port SRAM macro model
 * Byte-enabled writes, read data registered one cycle after the request
 */

`timescale 1ns/10ps

module sram_macro
  import mem_tile_pkg::*;
#(
  parameter  int unsigned NumWords = 256,
  localparam int unsigned AddrBits = $clog2(NumWords)
) (
  input  logic                       clk_i,
  input  logic                       req_i,
  input  logic                       we_i,
  input  logic [AddrBits-1:0]        addr_i,
  input  logic [BankDataWidth-1:0]   wdata_i,
  input  logic [BankDataWidth/8-1:0] be_i,
  output logic [BankDataWidth-1:0]   rdata_o
);

  logic [BankDataWidth-1:0] mem_q [NumWords];

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        for (int b = 0; b < BankDataWidth / 8; b++) begin
          if (be_i[b]) mem_q[addr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
        end
      end else begin
        rdata_o <= mem_q[addr_i];
      end
    end
  end

endmodule

// File: sram/sram_banks.sv
/*
 * Banked word memory
 * Each word is split over lane banks, each bank holds several macro
 * rows chosen by address bits above the macro address
 */

`timescale 1ns/10ps

module sram_banks
  import mem_tile_pkg::*;
#(
  parameter int unsigned NumBankRows  = 2,
  parameter int unsigned SramNumWords = 256
) (
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  logic      req_valid_i,
  input  sram_req_t req_i,
  output logic      rsp_valid_o,
  output mem_rsp_t  rsp_o
);

  localparam int unsigned ByteOffset    = $clog2(DataWidth / 8);
  localparam int unsigned SramAddrWidth = $clog2(SramNumWords);
  localparam int unsigned SelWidth      = (NumBankRows > 1) ? $clog2(NumBankRows) : 1;
  localparam int unsigned SelOffset     = ByteOffset + SramAddrWidth;
  localparam int unsigned LaneBytes     = BankDataWidth / 8;

  logic [SramAddrWidth-1:0] sram_addr;
  logic [SelWidth-1:0]      sel, sel_q;
  logic                     rsp_valid_q;
  logic [DataWidth-1:0]     rdata_word;

  logic [NumBankRows-1:0][NumBanksPerWord-1:0][BankDataWidth-1:0] rdata_split;

  // Word index sits above the byte offset, high bits are ignored
  assign sram_addr = req_i.addr[ByteOffset +: SramAddrWidth];
  assign sel       = req_i.addr[SelOffset +: SelWidth];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rsp_valid_q <= 1'b0;
      sel_q       <= '0;
    end else begin
      rsp_valid_q <= req_valid_i;
      // Remember which row answers the read on the next cycle
      if (req_valid_i && !req_i.we) sel_q <= sel;
    end
  end

  for (genvar i = 0; i < NumBanksPerWord; i++) begin : gen_lanes
    for (genvar j = 0; j < NumBankRows; j++) begin : gen_rows
      sram_macro #(
        .NumWords(SramNumWords)
      ) i_macro (
        .clk_i,
        .req_i  (req_valid_i && (sel == SelWidth'(j))),
        .we_i   (req_i.we),
        .addr_i (sram_addr),
        .wdata_i(req_i.wdata[i*BankDataWidth +: BankDataWidth]),
        .be_i   (req_i.be[i*LaneBytes +: LaneBytes]),
        .rdata_o(rdata_split[j][i])
      );
    end
    assign rdata_word[i*BankDataWidth +: BankDataWidth] = rdata_split[sel_q][i];
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_o.rdata = rdata_word;

endmodule

// File: rtl/req_cut.sv
/*
 * Register cut between the resolver and the SRAM banks
 * One stage on the request path and one on the response path
 */

`timescale 1ns/10ps

module req_cut
  import mem_tile_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  logic      req_valid_i,
  input  sram_req_t req_i,
  output logic      gnt_o,
  output logic      mem_req_valid_o,
  output sram_req_t mem_req_o,
  input  logic      mem_rsp_valid_i,
  input  mem_rsp_t  mem_rsp_i,
  output logic      rsp_valid_o,
  output mem_rsp_t  rsp_o
);

  logic      req_valid_q;
  sram_req_t req_q;
  logic      drain;
  logic      rsp_valid_q;
  mem_rsp_t  rsp_q;

  ////////////////////////////////////////
  // Request stage
  ////////////////////////////////////////

  // Banks accept every cycle, so a held request always leaves
  assign drain = req_valid_q;
  assign gnt_o = ~req_valid_q | drain;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      req_valid_q <= 1'b0;
    end else if (gnt_o) begin
      req_valid_q <= req_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_valid_i && gnt_o) req_q <= req_i;
  end

  assign mem_req_valid_o = req_valid_q;
  assign mem_req_o       = req_q;

  ////////////////////////////////////////
  // Response stage
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= mem_rsp_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    rsp_q <= mem_rsp_i;
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_o       = rsp_q;

endmodule

// File: atop/atop_resolver.sv
/*
 * Atomic operation resolver
 * Passes plain reads and writes straight on and turns atomics into a
 * read followed by a write, with a single response for the pair
 */

`timescale 1ns/10ps

module atop_resolver
  import mem_tile_pkg::*;
#(
  parameter int unsigned MaxOutstanding = 4
) (
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  logic      req_valid_i,
  input  mem_req_t  req_i,
  output logic      gnt_o,
  output logic      rsp_valid_o,
  output mem_rsp_t  rsp_o,
  output logic      cut_req_valid_o,
  output sram_req_t cut_req_o,
  input  logic      cut_gnt_i,
  input  logic      cut_rsp_valid_i,
  input  mem_rsp_t  cut_rsp_i
);

  localparam int unsigned CntWidth     = $clog2(MaxOutstanding + 1);
  localparam int unsigned LaneBit      = $clog2(AmoWidth / 8);
  localparam int unsigned LaneIdxWidth = $clog2(DataWidth / AmoWidth);

  typedef enum logic [2:0] {
    IDLE,
    AMO_DRAIN,
    AMO_READ,
    AMO_WAIT_READ,
    AMO_WRITE,
    AMO_WAIT_WRITE,
    AMO_RESP
  } state_e;

  state_e                  state_q, state_d;
  logic [CntWidth-1:0]     cnt_q;
  logic                    is_amo, room, plain_acc, plain_rsp;
  mem_req_t                amo_q;
  logic [AmoWidth-1:0]     old_q, operand, new_val;
  logic [LaneIdxWidth-1:0] lane;

  function automatic logic [AmoWidth-1:0] amo_calc(mem_op_e op, logic [AmoWidth-1:0] a,
                                                   logic [AmoWidth-1:0] b);
    case (op)
      AMO_SWAP: return b;
      AMO_ADD:  return a + b;
      AMO_AND:  return a & b;
      AMO_OR:   return a | b;
      AMO_MAXU: return (a > b) ? a : b;
      AMO_MINU: return (a < b) ? a : b;
      default:  return a;
    endcase
  endfunction

  assign is_amo  = (req_i.op != MEM_READ) && (req_i.op != MEM_WRITE);
  assign room    = cnt_q < CntWidth'(MaxOutstanding);
  assign lane    = amo_q.addr[LaneBit +: LaneIdxWidth];
  assign operand = amo_q.wdata[lane*AmoWidth +: AmoWidth];
  assign new_val = amo_calc(amo_q.op, old_q, operand);

  assign plain_acc = (state_q == IDLE) && cut_req_valid_o && cut_gnt_i;
  assign plain_rsp = cut_rsp_valid_i && ((state_q == IDLE) || (state_q == AMO_DRAIN));

  always_comb begin
    state_d         = state_q;
    gnt_o           = 1'b0;
    cut_req_valid_o = 1'b0;
    cut_req_o.we    = 1'b0;
    cut_req_o.addr  = amo_q.addr;
    cut_req_o.wdata = {(DataWidth/AmoWidth){new_val}};
    cut_req_o.be    = '0;
    rsp_valid_o     = plain_rsp;
    rsp_o           = cut_rsp_i;
    case (state_q)
      IDLE: begin
        if (req_valid_i && is_amo) begin
          state_d = AMO_DRAIN;
        end else begin
          gnt_o           = cut_gnt_i && room;
          cut_req_valid_o = req_valid_i && room;
          cut_req_o.we    = (req_i.op == MEM_WRITE);
          cut_req_o.addr  = req_i.addr;
          cut_req_o.wdata = req_i.wdata;
          cut_req_o.be    = req_i.be;
        end
      end
      AMO_DRAIN: begin
        // Grant only once every plain request has come back
        gnt_o = (cnt_q == '0);
        if (cnt_q == '0) state_d = AMO_READ;
      end
      AMO_READ: begin
        cut_req_valid_o = 1'b1;
        cut_req_o.be    = '1;
        if (cut_gnt_i) state_d = AMO_WAIT_READ;
      end
      AMO_WAIT_READ: begin
        if (cut_rsp_valid_i) state_d = AMO_WRITE;
      end
      AMO_WRITE: begin
        cut_req_valid_o = 1'b1;
        cut_req_o.we    = 1'b1;
        cut_req_o.be[lane*(AmoWidth/8) +: AmoWidth/8] = '1;
        if (cut_gnt_i) state_d = AMO_WAIT_WRITE;
      end
      AMO_WAIT_WRITE: begin
        if (cut_rsp_valid_i) state_d = AMO_RESP;
      end
      default: begin
        rsp_valid_o = 1'b1;
        rsp_o.rdata = '0;
        rsp_o.rdata[lane*AmoWidth +: AmoWidth] = old_q;
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_q + CntWidth'(plain_acc) - CntWidth'(plain_rsp);
    end
  end

  // Atomic operands and the old lane value
  always_ff @(posedge clk_i) begin
    if (state_q == AMO_DRAIN && gnt_o) amo_q <= req_i;
    if (state_q == AMO_WAIT_READ && cut_rsp_valid_i) begin
      old_q <= cut_rsp_i.rdata[lane*AmoWidth +: AmoWidth];
    end
  end

endmodule

// File: rtl/mem_tile.sv
/*
 * Memory tile top level
 * Atomic resolver, register cut and banked SRAM in a chain
 */

`timescale 1ns/10ps

module mem_tile
  import mem_tile_pkg::*;
#(
  parameter int unsigned NumBankRows    = 2,
  parameter int unsigned SramNumWords   = 256,
  parameter int unsigned MaxOutstanding = 4
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     req_valid_i,
  input  mem_req_t req_i,
  output logic     gnt_o,
  output logic     rsp_valid_o,
  output mem_rsp_t rsp_o
);

  logic      cut_req_valid;
  sram_req_t cut_req;
  logic      cut_gnt;
  logic      cut_rsp_valid;
  mem_rsp_t  cut_rsp;

  logic      mem_req_valid;
  sram_req_t mem_req;
  logic      bank_rsp_valid;
  mem_rsp_t  bank_rsp;

  atop_resolver #(
    .MaxOutstanding(MaxOutstanding)
  ) i_atop_resolver (
    .clk_i,
    .rst_n_i,
    .req_valid_i,
    .req_i,
    .gnt_o,
    .rsp_valid_o,
    .rsp_o,
    .cut_req_valid_o(cut_req_valid),
    .cut_req_o      (cut_req),
    .cut_gnt_i      (cut_gnt),
    .cut_rsp_valid_i(cut_rsp_valid),
    .cut_rsp_i      (cut_rsp)
  );

  req_cut i_req_cut (
    .clk_i,
    .rst_n_i,
    .req_valid_i    (cut_req_valid),
    .req_i          (cut_req),
    .gnt_o          (cut_gnt),
    .mem_req_valid_o(mem_req_valid),
    .mem_req_o      (mem_req),
    .mem_rsp_valid_i(bank_rsp_valid),
    .mem_rsp_i      (bank_rsp),
    .rsp_valid_o    (cut_rsp_valid),
    .rsp_o          (cut_rsp)
  );

  sram_banks #(
    .NumBankRows (NumBankRows),
    .SramNumWords(SramNumWords)
  ) i_sram_banks (
    .clk_i,
    .rst_n_i,
    .req_valid_i(mem_req_valid),
    .req_i      (mem_req),
    .rsp_valid_o(bank_rsp_valid),
    .rsp_o      (bank_rsp)
  );

endmodule

// File: tests/tb_mem_tile.sv
/*
 * Memory tile testbench
 * Random reads, writes and atomics against a byte-level memory model,
 * with in-order response matching and plain request latency checks
 */

`timescale 1ns/10ps

module tb_mem_tile
  import mem_tile_pkg::*;
();

  localparam int unsigned NumBankRows    = 2;
  localparam int unsigned SramNumWords   = 256;
  localparam int unsigned MaxOutstanding = 4;
  localparam int unsigned ModelWords     = NumBankRows * SramNumWords;
  localparam int unsigned WordIdxWidth   = $clog2(ModelWords);
  localparam int unsigned ByteOffset     = $clog2(DataWidth / 8);
  localparam int unsigned BeWidth        = DataWidth / 8;
  localparam int unsigned LaneSelBit     = $clog2(AmoWidth / 8);
  localparam int unsigned NumRandomOps   = 600;
  localparam int unsigned NumOps         = ModelWords + NumRandomOps;
  localparam int unsigned PlainLatency   = 3;
  localparam int unsigned ClkPeriod      = 40;

  typedef struct packed {
    logic                 plain;
    logic                 has_data;
    logic [DataWidth-1:0] data;
    logic [31:0]          gnt_cycle;
  } exp_rsp_t;

  logic     clk = 1'b0;
  logic     rst_n;
  logic     req_valid;
  mem_req_t req;
  logic     gnt;
  logic     rsp_valid;
  mem_rsp_t rsp;

  logic [7:0]           model_mem [ModelWords * BeWidth];
  exp_rsp_t             exp_q [$];
  logic [31:0]          cycle;
  logic [31:0]          lfsr;
  logic [AddrWidth-1:0] last_addr;
  logic                 amo_busy    = 1'b0;
  int unsigned          mon_errors  = 0;
  int unsigned          stim_errors = 0;
  int unsigned          rsp_count   = 0;

  mem_tile #(
    .NumBankRows   (NumBankRows),
    .SramNumWords  (SramNumWords),
    .MaxOutstanding(MaxOutstanding)
  ) DUT (
    .clk_i      (clk),
    .rst_n_i    (rst_n),
    .req_valid_i(req_valid),
    .req_i      (req),
    .gnt_o      (gnt),
    .rsp_valid_o(rsp_valid),
    .rsp_o      (rsp)
  );

  always #(ClkPeriod / 2) clk = ~clk;

  always @(posedge clk) begin
    if (!rst_n) cycle <= '0;
    else cycle <= cycle + 1;
  end

  ////////////////////////////////////////
  // Random numbers and reference model
  ////////////////////////////////////////

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [63:0] rand_bits(input int unsigned n);
    logic [63:0] v;
    v = '0;
    for (int unsigned i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v    = {v[62:0], lfsr[31]};
    end
    return v;
  endfunction

  function automatic logic [DataWidth-1:0] model_read(input logic [AddrWidth-1:0] a);
    logic [DataWidth-1:0] w;
    int unsigned          base;
    base = 32'(a[ByteOffset +: WordIdxWidth]) * BeWidth;
    for (int unsigned b = 0; b < BeWidth; b++) begin
      w[b*8 +: 8] = model_mem[base + b];
    end
    return w;
  endfunction

  task automatic model_write(input logic [AddrWidth-1:0] a, input logic [DataWidth-1:0] d,
                             input logic [BeWidth-1:0] be);
    int unsigned base;
    base = 32'(a[ByteOffset +: WordIdxWidth]) * BeWidth;
    for (int unsigned b = 0; b < BeWidth; b++) begin
      if (be[b]) model_mem[base + b] = d[b*8 +: 8];
    end
  endtask

  function automatic logic [AmoWidth-1:0] amo_expect(input mem_op_e op,
      input logic [AmoWidth-1:0] old, input logic [AmoWidth-1:0] opd);
    logic [AmoWidth-1:0] r;
    r = old;
    case (op)
      AMO_SWAP: r = opd;
      AMO_ADD:  r = old + opd;
      AMO_AND:  r = old & opd;
      AMO_OR:   r = old | opd;
      AMO_MAXU: if (opd > old) r = opd;
      AMO_MINU: if (opd < old) r = opd;
      default:  r = old;
    endcase
    return r;
  endfunction

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp,
                       inout int unsigned errors);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  ////////////////////////////////////////
  // Monitor
  ////////////////////////////////////////

  // Model is updated in grant order, which is also the memory order
  task automatic record_grant(input mem_req_t r);
    exp_rsp_t             e;
    logic [DataWidth-1:0] word;
    logic [AmoWidth-1:0]  old_lane;
    logic [AmoWidth-1:0]  new_lane;
    logic                 hi;
    if (amo_busy) begin
      mon_errors++;
      $display("Request granted at %0t while an atomic was still in progress", $time);
    end
    word        = model_read(r.addr);
    hi          = r.addr[LaneSelBit];
    e.gnt_cycle = cycle;
    e.plain     = 1'b1;
    e.has_data  = 1'b1;
    e.data      = word;
    if (r.op == MEM_WRITE) begin
      e.has_data = 1'b0;
      model_write(r.addr, r.wdata, r.be);
    end else if (r.op != MEM_READ) begin
      old_lane = hi ? word[AmoWidth +: AmoWidth] : word[0 +: AmoWidth];
      new_lane = amo_expect(r.op, old_lane,
                            hi ? r.wdata[AmoWidth +: AmoWidth] : r.wdata[0 +: AmoWidth]);
      e.plain  = 1'b0;
      e.data   = hi ? {old_lane, {AmoWidth{1'b0}}} : {{AmoWidth{1'b0}}, old_lane};
      model_write(r.addr, {new_lane, new_lane}, hi ? 8'hf0 : 8'h0f);
      amo_busy = 1'b1;
    end
    exp_q.push_back(e);
  endtask

  task automatic match_response();
    exp_rsp_t e;
    if (exp_q.size() == 0) begin
      mon_errors++;
      $display("Response at %0t with no request outstanding", $time);
    end else begin
      e = exp_q.pop_front();
      rsp_count++;
      if (e.has_data) check("rsp_o.rdata", rsp.rdata, e.data, mon_errors);
      if (e.plain) begin
        check("rsp_valid_o latency", 64'(cycle - e.gnt_cycle), 64'(PlainLatency),
              mon_errors);
      end else begin
        amo_busy = 1'b0;
      end
    end
  endtask

  // Sampled mid-cycle away from the driving edge
  always @(negedge clk) begin
    if (rst_n) begin
      if (req_valid && gnt) record_grant(req);
      if (rsp_valid) match_response();
    end
  end

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  // Hold one request until the cycle it is granted
  task automatic send(input mem_req_t r, output int unsigned waits);
    waits = 0;
    req_valid <= 1'b1;
    req       <= r;
    @(negedge clk);
    while (!gnt) begin
      waits++;
      @(negedge clk);
    end
    @(posedge clk);
  endtask

  task automatic idle_cycles(input int unsigned n);
    req_valid <= 1'b0;
    repeat (n) @(posedge clk);
  endtask

  task automatic run_random_op();
    mem_req_t    r;
    logic [2:0]  kind;
    logic        after_amo;
    int unsigned waits;
    kind    = 3'(rand_bits(3));
    r.op    = MEM_READ;
    r.addr  = AddrWidth'(rand_bits(AddrWidth));
    r.wdata = rand_bits(DataWidth);
    r.be    = '1;
    case (kind)
      3'd0, 3'd1: begin
        r.op = MEM_WRITE;
        r.be = BeWidth'(rand_bits(BeWidth));
      end
      3'd2: r.op = MEM_READ;
      3'd3, 3'd4: r.addr = last_addr;
      default: r.op = mem_op_e'(3'd2 + 3'(rand_bits(3) % 6));
    endcase
    if (r.op != MEM_READ) last_addr = r.addr;
    after_amo = amo_busy;
    send(r, waits);
    // A plain request with no atomic in flight is granted at once
    if (!after_amo && (r.op == MEM_READ || r.op == MEM_WRITE)) begin
      check("gnt_o wait cycles", 64'(waits), 64'd0, stim_errors);
    end
    if (rand_bits(2) == 0) idle_cycles(32'(rand_bits(2)) + 1);
  endtask

  initial begin
    mem_req_t    r;
    int unsigned waits;
    lfsr       = 32'hf982;
    last_addr  = '0;
    rst_n     <= 1'b0;
    req_valid <= 1'b0;
    req       <= '0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;

    repeat (2) begin
      @(negedge clk);
      check("rsp_valid_o", 64'(rsp_valid), 64'd0, stim_errors);
      check("gnt_o", 64'(gnt), 64'd1, stim_errors);
    end
    @(posedge clk);

    // Back-to-back full-word fill so every later read is defined
    for (int unsigned w = 0; w < ModelWords; w++) begin
      r.op    = MEM_WRITE;
      r.addr  = AddrWidth'(w << ByteOffset);
      r.wdata = rand_bits(DataWidth);
      r.be    = '1;
      send(r, waits);
      check("gnt_o wait cycles", 64'(waits), 64'd0, stim_errors);
    end

    for (int unsigned n = 0; n < NumRandomOps; n++) begin
      run_random_op();
    end

    idle_cycles(1);
    while (exp_q.size() != 0) @(negedge clk);
    repeat (4) @(negedge clk);

    $display("Responses checked: %0d, stimulus errors: %0d, response errors: %0d",
             rsp_count, stim_errors, mon_errors);
    if (stim_errors == 0 && mon_errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // Each operation gets a generous 20 cycles
  initial begin
    #(NumOps * 20 * ClkPeriod);
    $display("Watchdog timeout: the run did not finish in time, responses may be missing");
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

// File: flist.f
common/mem_tile_pkg.sv
sram/sram_macro.sv
sram/sram_banks.sv
rtl/req_cut.sv
atop/atop_resolver.sv
rtl/mem_tile.sv
tests/tb_mem_tile.sv

// File: run_sim.sh
#!/bin/sh
# Build the memory tile testbench with Verilator, run it and check the log

BUILD_DIR=obj_dir
LOG=sim.log
TOP=tb_mem_tile

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f flist.f --top-module "$TOP" \
  --Mdir "$BUILD_DIR" -o "$TOP"
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

"./$BUILD_DIR/$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "SIMULATION PASSED" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1
